/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = mbus_tb
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* files.f */
rtl/mbus_pkg.sv
rtl/byte_lane_ram.sv
rtl/mbus_decoder.sv
rtl/mbus_cmd_fifo.sv
rtl/mbus_target_ctrl.sv
rtl/mbus_top.sv
sim/mbus_tb_rom.sv
sim/mbus_tb.sv

/* rtl/byte_lane_ram.sv */
// Byte lane RAM
// Synchronous single-port RAM built from 8-bit lanes, each with its
// own write enable. Read data is registered.

`timescale 1ns/100ps

module byte_lane_ram #(
	parameter int ADDR_W = 15,
	parameter int LANES  = 2
) (
	input  logic                 MCLK,
	input  logic [ADDR_W-1:0]    addr,
	input  logic [8*LANES-1:0]   wdata,
	input  logic [LANES-1:0]     we,
	output logic [8*LANES-1:0]   rdata
);

	logic [8*LANES-1:0] mem [2**ADDR_W];

	always_ff @(posedge MCLK) begin
		for (int l = 0; l < LANES; l++) begin
			if (we[l]) begin
				mem[addr][8*l +: 8] <= wdata[8*l +: 8];
			end
		end
		// Old data on a write cycle
		rdata <= mem[addr];
	end

endmodule

/* rtl/mbus_cmd_fifo.sv */
// Command queue
// Circular buffer between the decoder and the target controller.
// Each pop frees one slot, which the top returns as a credit.

`timescale 1ns/100ps

module mbus_cmd_fifo
	import mbus_pkg::*;
#(
	parameter int FIFO_DEPTH = 4
) (
	input  logic     MCLK,
	input  logic     reset,
	input  logic     cmd_push_valid,
	input  bus_cmd_t cmd_push,
	output logic     cmd_valid,
	output bus_cmd_t cmd,
	input  logic     cmd_pop
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	bus_cmd_t           mem [FIFO_DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [CNT_W-1:0]   count;

	assign cmd_valid = (count != '0);
	assign cmd       = mem[rd_ptr];

	always_ff @(posedge MCLK) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (cmd_push_valid) begin
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (cmd_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leaves the count unchanged
			if (cmd_push_valid && !cmd_pop) begin
				count <= count + 1'b1;
			end else if (cmd_pop && !cmd_push_valid) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge MCLK) begin
		if (cmd_push_valid) begin
			mem[wr_ptr] <= cmd_push;
		end
	end

	a_no_overflow: assert property (
		@(posedge MCLK) disable iff (reset)
		cmd_push_valid |-> (count != CNT_W'(FIFO_DEPTH)) || cmd_pop
	) else $error("command pushed into a full queue");

	a_no_underflow: assert property (
		@(posedge MCLK) disable iff (reset)
		cmd_pop |-> cmd_valid
	) else $error("command popped from an empty queue");

endmodule

/* rtl/mbus_decoder.sv */
// Main bus address decoder
// Classifies each request into a target command for the queue and
// keeps the cartridge bank registers and the bank mode.

`timescale 1ns/100ps

module mbus_decoder
	import mbus_pkg::*;
(
	input  logic        MCLK,
	input  logic        reset,
	input  logic        req_valid,
	input  bus_req_t    req,
	input  logic [24:1] rom_size,
	output logic        cmd_push_valid,
	output bus_cmd_t    cmd_push
);

	logic [4:0]  bank_reg [8];
	bank_mode_e  bank_mode;
	target_e     target;
	logic [24:1] rom_addr;
	logic        rom_banked;

	// ---------------------------------------------------------------------
	// Address classification
	// ---------------------------------------------------------------------
	always_comb begin
		rom_banked = {rom_size, 1'b0} > ROM_BANK_LIMIT;

		if ({req.addr, 1'b0} < ROM_SPACE_END) begin
			// SRAM overrides ROM in 200000-3FFFFF when banked in
			if (bank_mode == BANK_SRAM && req.addr[23:21] == SRAM_WINDOW) begin
				target = TGT_SRAM;
			end else if ({1'b0, req.addr} < rom_size) begin
				target = TGT_ROM;
			end else if (req.addr[23:21] == SRAM_WINDOW && !(&req.addr[20:19])) begin
				target = TGT_SRAM;
			end else begin
				target = TGT_ROM_HOLE;
			end
		end else if (req.addr[23:8] == BANK_REG_PAGE) begin
			target = TGT_BANK;
		end else if (req.addr[23:21] == WRAM_WINDOW) begin
			target = TGT_WRAM;
		end else begin
			target = TGT_NONE;
		end

		// 512K pages picked by address bits 21:19
		if (bank_mode == BANK_ROM) begin
			rom_addr = {1'b0, bank_reg[req.addr[21:19]], req.addr[18:1]};
		end else begin
			rom_addr = {1'b0, req.addr};
		end
	end

	// ---------------------------------------------------------------------
	// Bank registers
	// ---------------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			cmd_push_valid <= 1'b0;
			bank_mode      <= BANK_NONE;
			for (int i = 0; i < 8; i++) begin
				bank_reg[i] <= 5'(i);
			end
		end else begin
			cmd_push_valid <= req_valid;
			if (req_valid && !req.rnw && target == TGT_BANK) begin
				if (rom_banked) begin
					// Register 0 is fixed to the first page
					if (req.addr[3:1] != 3'd0) begin
						bank_reg[req.addr[3:1]] <= req.wdata[4:0];
						bank_mode               <= BANK_ROM;
					end
				end else begin
					bank_mode <= req.wdata[0] ? BANK_SRAM : BANK_NONE;
				end
			end
		end
	end

	// Command payload
	always_ff @(posedge MCLK) begin
		cmd_push.target   <= target;
		cmd_push.rom_addr <= rom_addr;
		cmd_push.ram_addr <= req.addr[16:1];
		cmd_push.wdata    <= req.wdata;
		cmd_push.rnw      <= req.rnw;
		cmd_push.be       <= req.be;
	end

	a_req_addr_known: assert property (
		@(posedge MCLK) disable iff (reset)
		req_valid |-> !$isunknown(req.addr)
	) else $error("request with unknown address");

endmodule

/* rtl/mbus_pkg.sv */
// Main bus package
// Request, response and command types for the 68000 main bus,
// target and state encodings, and the address map constants.

package mbus_pkg;

	// Word request from the bus master
	typedef struct packed {
		logic [23:1] addr;
		logic [15:0] wdata;
		logic        rnw;
		logic [1:0]  be;
	} bus_req_t;

	typedef struct packed {
		logic [15:0] rdata;
	} bus_rsp_t;

	typedef enum logic [2:0] {
		TGT_ROM,
		TGT_SRAM,
		TGT_WRAM,
		TGT_BANK,
		TGT_ROM_HOLE,
		TGT_NONE
	} target_e;

	// Decoded command as held in the queue
	typedef struct packed {
		target_e     target;
		logic [24:1] rom_addr;
		logic [15:0] ram_addr;
		logic [15:0] wdata;
		logic        rnw;
		logic [1:0]  be;
	} bus_cmd_t;

	typedef enum logic [2:0] {
		CS_IDLE,
		CS_RAM_WAIT,
		CS_ROM_WAIT,
		CS_RESPOND
	} ctrl_state_e;

	typedef enum logic [1:0] {
		BANK_NONE,
		BANK_SRAM,
		BANK_ROM
	} bank_mode_e;

	// ---------------------------------------------------------------------
	// Address map
	// ---------------------------------------------------------------------
	localparam logic [15:0] OPEN_BUS_RESET = 16'h4E71;
	localparam logic [23:0] ROM_SPACE_END  = 24'hA00000;
	// Compared against address bits 23:21
	localparam logic [2:0]  SRAM_WINDOW    = 3'b001;
	localparam logic [2:0]  WRAM_WINDOW    = 3'b111;
	// Compared against address bits 23:8
	localparam logic [15:0] BANK_REG_PAGE  = 16'hA130;
	// Byte size above which the bank page drives ROM banking
	localparam logic [24:0] ROM_BANK_LIMIT = 25'h0200000;

endpackage

/* rtl/mbus_target_ctrl.sv */
// Main bus target controller
// Runs queued commands against cartridge ROM, save RAM and work RAM,
// keeps the open-bus value and returns one response per command.

`timescale 1ns/100ps

module mbus_target_ctrl
	import mbus_pkg::*;
#(
	parameter int WRAM_ADDR_W = 15,
	parameter int SRAM_ADDR_W = 16
) (
	input  logic        MCLK,
	input  logic        reset,
	input  logic        cmd_valid,
	input  bus_cmd_t    cmd,
	output logic        cmd_pop,
	output logic [24:1] rom_addr,
	output logic        rom_req,
	input  logic        rom_ack,
	input  logic [15:0] rom_data,
	output logic        rsp_valid,
	output bus_rsp_t    rsp
);

	ctrl_state_e state;
	target_e     cur_target;
	logic        cur_rnw;
	logic [15:0] open_bus;
	logic [15:0] wram_q;
	logic [7:0]  sram_q;
	logic [15:0] ram_word;
	logic [1:0]  wram_we;
	logic        sram_we;

	assign cmd_pop = (state == CS_IDLE) && cmd_valid;

	// RAMs see the head command so the read data is ready one cycle after the pop
	assign wram_we = {2{cmd_pop && cmd.target == TGT_WRAM && !cmd.rnw}} & cmd.be;
	assign sram_we = cmd_pop && cmd.target == TGT_SRAM && !cmd.rnw && (|cmd.be);

	byte_lane_ram #(
		.ADDR_W (WRAM_ADDR_W),
		.LANES  (2)
	) u_wram (
		.MCLK  (MCLK),
		.addr  (cmd.ram_addr[WRAM_ADDR_W-1:0]),
		.wdata (cmd.wdata),
		.we    (wram_we),
		.rdata (wram_q)
	);

	// Save RAM is byte wide on the low data lane
	byte_lane_ram #(
		.ADDR_W (SRAM_ADDR_W),
		.LANES  (1)
	) u_sram (
		.MCLK  (MCLK),
		.addr  (cmd.ram_addr[SRAM_ADDR_W-1:0]),
		.wdata (cmd.wdata[7:0]),
		.we    (sram_we),
		.rdata (sram_q)
	);

	assign ram_word = (cur_target == TGT_WRAM) ? wram_q : {sram_q, sram_q};

	// ---------------------------------------------------------------------
	// Control FSM
	// ---------------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state     <= CS_IDLE;
			rsp_valid <= 1'b0;
			rom_req   <= 1'b0;
			open_bus  <= OPEN_BUS_RESET;
		end else begin
			rsp_valid <= 1'b0;
			case (state)
				CS_IDLE: begin
					if (cmd_valid) begin
						case (cmd.target)
							TGT_WRAM, TGT_SRAM: state <= CS_RAM_WAIT;
							TGT_ROM: begin
								// ROM writes are dropped
								if (cmd.rnw) begin
									rom_req <= ~rom_req;
									state   <= CS_ROM_WAIT;
								end else begin
									state <= CS_RESPOND;
								end
							end
							default: state <= CS_RESPOND;
						endcase
					end
				end
				CS_RAM_WAIT: begin
					rsp_valid <= 1'b1;
					if (cur_rnw) begin
						open_bus <= ram_word;
					end
					state <= CS_IDLE;
				end
				CS_ROM_WAIT: begin
					if (rom_ack == rom_req) begin
						rsp_valid <= 1'b1;
						open_bus  <= rom_data;
						state     <= CS_IDLE;
					end
				end
				CS_RESPOND: begin
					rsp_valid <= 1'b1;
					state     <= CS_IDLE;
				end
				default: state <= CS_IDLE;
			endcase
		end
	end

	// Payload and response data
	always_ff @(posedge MCLK) begin
		if (cmd_pop) begin
			cur_target <= cmd.target;
			cur_rnw    <= cmd.rnw;
			if (cmd.target == TGT_ROM) begin
				rom_addr <= cmd.rom_addr;
			end
		end
		case (state)
			CS_RAM_WAIT: rsp.rdata <= cur_rnw ? ram_word : open_bus;
			CS_ROM_WAIT: begin
				if (rom_ack == rom_req) begin
					rsp.rdata <= rom_data;
				end
			end
			CS_RESPOND: begin
				// Reads in the ROM hole float low
				rsp.rdata <= (cur_rnw && cur_target == TGT_ROM_HOLE) ? 16'h0000 : open_bus;
			end
			default: ;
		endcase
	end

	a_rom_ack_in_wait: assert property (
		@(posedge MCLK) disable iff (reset)
		$changed(rom_ack) |-> state == CS_ROM_WAIT
	) else $error("ROM acknowledge outside a ROM access");

endmodule

/* rtl/mbus_top.sv */
// Main bus top level
// Decoder, command queue and target controller. Credits come back to
// the master as one pulse per command the queue releases.

`timescale 1ns/100ps

module mbus_top
	import mbus_pkg::*;
#(
	parameter int FIFO_DEPTH  = 4,
	parameter int WRAM_ADDR_W = 15,
	parameter int SRAM_ADDR_W = 16
) (
	input  logic        MCLK,
	input  logic        reset,
	input  logic        req_valid,
	input  bus_req_t    req,
	output logic        req_credit,
	output logic        rsp_valid,
	output bus_rsp_t    rsp,
	input  logic [24:1] rom_size,
	output logic [24:1] rom_addr,
	output logic        rom_req,
	input  logic        rom_ack,
	input  logic [15:0] rom_data
);

	logic     cmd_push_valid;
	bus_cmd_t cmd_push;
	logic     cmd_valid;
	bus_cmd_t cmd;
	logic     cmd_pop;

	assign req_credit = cmd_pop;

	mbus_decoder u_decoder (
		.MCLK           (MCLK),
		.reset          (reset),
		.req_valid      (req_valid),
		.req            (req),
		.rom_size       (rom_size),
		.cmd_push_valid (cmd_push_valid),
		.cmd_push       (cmd_push)
	);

	mbus_cmd_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_cmd_fifo (
		.MCLK           (MCLK),
		.reset          (reset),
		.cmd_push_valid (cmd_push_valid),
		.cmd_push       (cmd_push),
		.cmd_valid      (cmd_valid),
		.cmd            (cmd),
		.cmd_pop        (cmd_pop)
	);

	mbus_target_ctrl #(
		.WRAM_ADDR_W (WRAM_ADDR_W),
		.SRAM_ADDR_W (SRAM_ADDR_W)
	) u_target_ctrl (
		.MCLK      (MCLK),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.cmd_pop   (cmd_pop),
		.rom_addr  (rom_addr),
		.rom_req   (rom_req),
		.rom_ack   (rom_ack),
		.rom_data  (rom_data),
		.rsp_valid (rsp_valid),
		.rsp       (rsp)
	);

endmodule

/* sim/mbus_tb.sv */
// Main bus testbench
// Issues a table of requests to the main bus top level under credit
// flow control, pairs the responses in order and checks each one.

`timescale 1ns/100ps

module mbus_tb
	import mbus_pkg::*;
();

	localparam int          FIFO_DEPTH = 4;
	localparam logic [24:0] SZ_1M      = 25'h0100000;
	localparam logic [24:0] SZ_4M      = 25'h0400000;

	// One request and what its response must show
	typedef struct packed {
		logic        rnw;
		logic [23:0] addr;
		logic [15:0] wdata;
		logic [1:0]  be;
		logic [24:0] size;
		logic [15:0] exp_data;
		logic        chk_data;
		logic        chk_rom;
		logic [23:0] exp_rom;
	} entry_t;

	logic        MCLK;
	logic        reset;
	logic        req_valid;
	bus_req_t    req;
	logic        req_credit;
	logic        rsp_valid;
	bus_rsp_t    rsp;
	logic [24:1] rom_size;
	logic [24:1] rom_addr;
	logic        rom_req;
	logic        rom_ack;
	logic [15:0] rom_data;

	entry_t tbl [$];
	bit     table_ready = 1'b0;
	integer seed = 49;
	int     credits;
	int     issued;
	int     rsp_count;
	int     errors;
	int     gap;

	mbus_top #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) DUT (
		.MCLK       (MCLK),
		.reset      (reset),
		.req_valid  (req_valid),
		.req        (req),
		.req_credit (req_credit),
		.rsp_valid  (rsp_valid),
		.rsp        (rsp),
		.rom_size   (rom_size),
		.rom_addr   (rom_addr),
		.rom_req    (rom_req),
		.rom_ack    (rom_ack),
		.rom_data   (rom_data)
	);

	mbus_tb_rom u_rom (
		.MCLK     (MCLK),
		.reset    (reset),
		.rom_addr (rom_addr),
		.rom_req  (rom_req),
		.rom_ack  (rom_ack),
		.rom_data (rom_data)
	);

	initial begin
		MCLK = 1'b0;
		forever #50 MCLK = ~MCLK;
	end

	// ROM model data for a word address
	function automatic logic [15:0] rom_word(input logic [23:0] word);
		return word[15:0] ^ 16'hA5C3;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp, output bit ok);
		ok = (got === exp);
		if (!ok) begin
			$display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic table_entry(input logic rnw, input logic [23:0] addr,
			input logic [15:0] wdata, input logic [1:0] be, input logic [24:0] size,
			input logic [15:0] exp_data, input logic chk_data, input logic chk_rom,
			input logic [23:0] exp_rom);
		tbl.push_back(entry_t'{rnw, addr, wdata, be, size, exp_data, chk_data, chk_rom,
			exp_rom});
	endtask

	// -----------------------------------------------------------------------
	// Stimulus table
	// rnw, byte address, wdata, be, cartridge size, rdata, check, check rom_addr, word
	// -----------------------------------------------------------------------
	task automatic build_table();
		table_entry(1, 24'hB00000, 16'h0, 3, SZ_1M, 16'h4E71, 1, 0, 24'h0);
		table_entry(1, 24'h180000, 16'h0, 3, SZ_1M, 16'h0000, 1, 0, 24'h0);
		table_entry(1, 24'hB00000, 16'h0, 3, SZ_1M, 16'h4E71, 1, 0, 24'h0);
		// Work RAM byte enables
		table_entry(0, 24'hFF0000, 16'h1234, 3, SZ_1M, 16'h4E71, 1, 0, 24'h0);
		table_entry(0, 24'hFF0000, 16'hABCD, 2, SZ_1M, 16'h4E71, 1, 0, 24'h0);
		table_entry(1, 24'hFF0000, 16'h0, 3, SZ_1M, 16'hAB34, 1, 0, 24'h0);
		table_entry(1, 24'hB00000, 16'h0, 3, SZ_1M, 16'hAB34, 1, 0, 24'h0);
		table_entry(1, 24'h001234, 16'h0, 3, SZ_1M, rom_word(24'h00091A), 1, 1, 24'h00091A);
		table_entry(1, 24'hB00000, 16'h0, 3, SZ_1M, rom_word(24'h00091A), 1, 0, 24'h0);
		// Bank register 1 gets page 9
		table_entry(0, 24'hA13002, 16'h9, 3, SZ_4M, rom_word(24'h00091A), 1, 0, 24'h0);
		table_entry(1, 24'h080010, 16'h0, 3, SZ_4M, rom_word(24'h240008), 1, 1, 24'h240008);
		// Save RAM and its bank mode
		table_entry(0, 24'h200000, 16'h5A, 1, SZ_1M, rom_word(24'h240008), 1, 0, 24'h0);
		table_entry(1, 24'h200000, 16'h0, 3, SZ_1M, 16'h5A5A, 1, 0, 24'h0);
		table_entry(0, 24'hA130F0, 16'h1, 3, SZ_1M, 16'h5A5A, 1, 0, 24'h0);
		table_entry(1, 24'h200000, 16'h0, 3, SZ_1M, 16'h5A5A, 1, 0, 24'h0);
		table_entry(1, 24'h200000, 16'h0, 3, SZ_4M, 16'h5A5A, 1, 0, 24'h0);
		table_entry(0, 24'hA130F0, 16'h0, 3, SZ_1M, 16'h5A5A, 1, 0, 24'h0);
		table_entry(1, 24'h200000, 16'h0, 3, SZ_1M, 16'h5A5A, 1, 0, 24'h0);
		table_entry(1, 24'h200000, 16'h0, 3, SZ_4M, rom_word(24'h100000), 1, 1, 24'h100000);
		table_entry(1, 24'hB00000, 16'h0, 3, SZ_1M, rom_word(24'h100000), 1, 0, 24'h0);
		// Burst against slow ROM
		table_entry(1, 24'h000002, 16'h0, 3, SZ_1M, rom_word(24'h000001), 1, 1, 24'h000001);
		table_entry(1, 24'h0ABCDE, 16'h0, 3, SZ_1M, rom_word(24'h055E6F), 1, 1, 24'h055E6F);
		table_entry(1, 24'h0FFFFE, 16'h0, 3, SZ_1M, rom_word(24'h07FFFF), 1, 1, 24'h07FFFF);
		table_entry(1, 24'h012346, 16'h0, 3, SZ_1M, rom_word(24'h0091A3), 1, 1, 24'h0091A3);
		table_entry(0, 24'hFF1000, 16'hBEEF, 3, SZ_1M, rom_word(24'h0091A3), 1, 0, 24'h0);
		table_entry(1, 24'hFF1000, 16'h0, 3, SZ_1M, 16'hBEEF, 1, 0, 24'h0);
		table_entry(1, 24'h055554, 16'h0, 3, SZ_1M, rom_word(24'h02AAAA), 1, 1, 24'h02AAAA);
		table_entry(1, 24'hB00000, 16'h0, 3, SZ_1M, rom_word(24'h02AAAA), 1, 0, 24'h0);
	endtask

	// Pairs a response with the oldest outstanding request
	task automatic score_response();
		entry_t e;
		bit     ok_data;
		bit     ok_rom;
		ok_data = 1'b1;
		ok_rom  = 1'b1;
		if (rsp_count >= issued) begin
			$display("response at %0t with no request outstanding", $time);
			errors++;
		end else begin
			e = tbl[rsp_count];
			if (e.chk_data) begin
				check_value("rdata", 32'(rsp.rdata), 32'(e.exp_data), ok_data);
			end
			if (e.chk_rom) begin
				check_value("rom_addr", 32'(rom_addr), 32'(e.exp_rom), ok_rom);
			end
			$display("test %0d: %s %h -> %h %s", rsp_count, e.rnw ? "read " : "write",
				e.addr, rsp.rdata, (ok_data && ok_rom) ? "ok" : "bad");
			rsp_count++;
		end
	endtask

	// One clock: collect credits and responses, then maybe issue
	task automatic advance_cycle();
		entry_t e;
		@(negedge MCLK);
		credits += int'(req_credit);
		if (credits > FIFO_DEPTH) begin
			$display("credit count went above the queue depth at %0t", $time);
			errors++;
		end
		if (rsp_valid) begin
			score_response();
		end
		req_valid = 1'b0;
		if (gap > 0) begin
			gap--;
		end else if (issued < tbl.size() && credits > 0) begin
			e         = tbl[issued];
			req.addr  = e.addr[23:1];
			req.wdata = e.wdata;
			req.rnw   = e.rnw;
			req.be    = e.be;
			rom_size  = e.size[24:1];
			req_valid = 1'b1;
			credits--;
			issued++;
			gap = $unsigned($random(seed)) % 3;
		end
	endtask

	initial begin : main
		bit ok;
		reset     = 1'b1;
		req_valid = 1'b0;
		req       = '0;
		rom_size  = SZ_1M[24:1];
		credits   = FIFO_DEPTH;
		issued    = 0;
		rsp_count = 0;
		errors    = 0;
		gap       = 0;
		build_table();
		table_ready = 1'b1;
		repeat (10) @(negedge MCLK);
		reset = 1'b0;
		while (rsp_count < tbl.size()) begin
			advance_cycle();
		end
		// Stray responses would show up here
		repeat (10) begin
			advance_cycle();
		end
		check_value("credits held", credits, FIFO_DEPTH, ok);
		$display("%0d requests, %0d responses, %0d errors", issued, rsp_count, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin : watchdog
		wait (table_ready);
		repeat (10 + 20 * tbl.size()) @(posedge MCLK);
		$display("timeout: only %0d of %0d responses arrived", rsp_count, tbl.size());
		$display("Test failed");
		$finish;
	end

endmodule

/* sim/mbus_tb_rom.sv */
// Cartridge ROM model
// Answers each toggle of rom_req after a random delay of 1 to 5 clock
// cycles. Data is the low 16 bits of the word address XOR A5C3.

`timescale 1ns/100ps

module mbus_tb_rom (
	input  logic        MCLK,
	input  logic        reset,
	input  logic [24:1] rom_addr,
	input  logic        rom_req,
	output logic        rom_ack,
	output logic [15:0] rom_data
);

	integer seed = 49;
	integer delay;

	// Outputs change on the falling edge only
	initial begin
		rom_ack  = 1'b0;
		rom_data = 16'h0000;
		forever begin
			@(negedge MCLK);
			if (!reset && rom_req != rom_ack) begin
				delay = 1 + ($unsigned($random(seed)) % 5);
				repeat (delay) @(negedge MCLK);
				rom_data = rom_addr[16:1] ^ 16'hA5C3;
				rom_ack  = rom_req;
			end
		end
	end

endmodule
